// ==== design/posit_fmt_pkg.sv ====
package posit_fmt_pkg;

    // Default posit format
    localparam int default_n  = 16;
    localparam int default_es = 1;

    // Width of the signed combined scale
    // Holds regime times 2^ES plus exponent for a full product
    function automatic int scale_w(int n, int es);
        return $clog2(n) + es + 3;
    endfunction

    // Decoded fraction with hidden bit
    function automatic int frac_w(int n, int es);
        return n - es - 2;
    endfunction

    // Product fraction handed to the encoder
    // Two guard positions below the raw product
    function automatic int prod_w(int n, int es);
        return 2 * (n - es - 1);
    endfunction

endpackage

// ==== design/posit_hs_pkg.sv ====
package posit_hs_pkg;

    // Phases of a four-phase req/ack exchange
    typedef enum logic [1:0] {
        idle,
        req_seen,
        ack_high,
        wait_low
    } hs_phase_e;

endpackage

// ==== design/posit_decode.sv ====
`timescale 1ns/1ps

module posit_decode #(
    parameter int N  = posit_fmt_pkg::default_n,
    parameter int ES = posit_fmt_pkg::default_es
) (
    input  logic [N-1:0]                                 p,
    output logic                                         sign,
    output logic                                         zero,
    output logic                                         nar,
    output logic signed [posit_fmt_pkg::scale_w(N, ES)-1:0] scale,
    output logic [posit_fmt_pkg::frac_w(N, ES)-1:0]      frac
);
    import posit_fmt_pkg::*;

    localparam int SW = scale_w(N, ES);
    localparam int RW = $clog2(N) + 1;

    logic [N-1:0]         mag;
    logic [N-2:0]         body;
    logic [N-2:0]         rem;
    logic [RW-1:0]        run;
    logic                 run_end;
    logic signed [SW-1:0] k;
    logic [ES-1:0]        exp_bits;

    always_comb
    begin
        // Specials
        sign = p[N-1];
        zero = (p == '0);
        nar  = (p == {1'b1, {(N-1){1'b0}}});

        // Work on the magnitude
        mag  = sign ? -p : p;
        body = mag[N-2:0];

        // Length of the regime run
        run     = '0;
        run_end = 1'b0;
        for (int i = N - 2; i >= 0; i--)
        begin
            if (!run_end && body[i] == body[N-2])
                run = run + 1'b1;
            else
                run_end = 1'b1;
        end

        // Ones give k = run - 1, zeros give k = -run
        k = body[N-2] ? $signed(SW'(run)) - 1 : -$signed(SW'(run));

        // Drop regime and terminator
        rem = body << (run + 1'b1);

        // Exponent bits sit right below the regime
        exp_bits = rem[N-2 -: ES];
        scale    = (k <<< ES) + $signed({1'b0, exp_bits});

        // Hidden one on top, fraction left aligned
        frac = {1'b1, rem[N-2-ES:2]};
    end

endmodule

// ==== design/posit_rounding.sv ====
`timescale 1ns/1ps

module posit_rounding #(
    parameter int N  = posit_fmt_pkg::default_n,
    parameter int ES = posit_fmt_pkg::default_es
) (
    input  logic                                         sign,
    input  logic                                         zero,
    input  logic                                         nar,
    input  logic signed [posit_fmt_pkg::scale_w(N, ES)-1:0] scale,
    input  logic [posit_fmt_pkg::prod_w(N, ES)-1:0]      frac,
    output logic [N-1:0]                                 p
);
    import posit_fmt_pkg::*;

    localparam int SW   = scale_w(N, ES);
    localparam int PW   = prod_w(N, ES);
    // Bits behind the regime terminator
    localparam int TW   = ES + PW - 1;
    localparam int KMAX = N - 2;

    logic signed [SW-1:0] k;
    logic [ES-1:0]        e;
    logic [SW-1:0]        run_len;
    logic                 run_bit;
    logic [N+TW-1:0]      z;
    logic [N+TW-1:0]      z_sh;
    logic [N-2:0]         body;
    logic                 guard;
    logic                 sticky;
    logic                 rnd;
    logic [N-1:0]         mag;

    //////////////////////////////////////////////////////////////////////
    // Regime, exponent and fraction packing
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        // Floor split of the scale
        k = scale >>> ES;
        e = scale[ES-1:0];

        // Ones for k >= 0, zeros for k < 0
        run_bit = ~k[SW-1];
        run_len = k[SW-1] ? -k : k + 1;

        // Full run, terminator, exponent, fraction without hidden one
        z    = {{(N-1){run_bit}}, ~run_bit, e, frac[PW-2:0]};
        // Keep only run_len copies of the run bit
        z_sh = z << (N - 1 - run_len);

        // Body of the posit and the bits cut off below it
        body   = z_sh[N+TW-1 -: N-1];
        guard  = z_sh[TW];
        sticky = |z_sh[TW-1:0];
        // Half to even
        rnd    = guard & (sticky | body[0]);

        // Body never all ones here, no carry into the sign
        mag = {1'b0, body} + N'(rnd);

        // Saturate at maxpos and minpos
        if (k >= KMAX)
            mag = {1'b0, {(N-1){1'b1}}};
        else if (k < -KMAX)
            mag = N'(1);

        p = sign ? -mag : mag;

        // Specials override, NaR first
        if (zero)
            p = '0;
        if (nar)
            p = {1'b1, {(N-1){1'b0}}};
    end

endmodule

// ==== design/posit_mul_lane.sv ====
`timescale 1ns/1ps

module posit_mul_lane #(
    parameter int N  = posit_fmt_pkg::default_n,
    parameter int ES = posit_fmt_pkg::default_es
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         lane_req,
    input  logic [N-1:0] lane_a,
    input  logic [N-1:0] lane_b,
    input  logic         res_ack,
    output logic         lane_ack,
    output logic         res_req,
    output logic [N-1:0] res_val
);
    import posit_fmt_pkg::*;
    import posit_hs_pkg::*;

    localparam int SW = scale_w(N, ES);
    localparam int FW = frac_w(N, ES);

    hs_phase_e            req_ph;
    hs_phase_e            res_ph;
    logic                 busy;
    logic                 cap_v;
    logic                 s1_v;
    logic [N-1:0]         a_q;
    logic [N-1:0]         b_q;
    logic                 sa;
    logic                 sb;
    logic                 za;
    logic                 zb;
    logic                 na;
    logic                 nb;
    logic signed [SW-1:0] sc_a;
    logic signed [SW-1:0] sc_b;
    logic [FW-1:0]        fa;
    logic [FW-1:0]        fb;
    logic [2*FW-1:0]      prod;
    logic                 s1_sign;
    logic                 s1_zero;
    logic                 s1_nar;
    logic signed [SW-1:0] s1_scale;
    logic [2*FW-1:0]      s1_prod;
    logic [N-1:0]         rnd_p;

    posit_decode #(.N(N), .ES(ES)) u_dec_a (
        .p(a_q), .sign(sa), .zero(za), .nar(na), .scale(sc_a), .frac(fa)
    );

    posit_decode #(.N(N), .ES(ES)) u_dec_b (
        .p(b_q), .sign(sb), .zero(zb), .nar(nb), .scale(sc_b), .frac(fb)
    );

    // Both factors in [1,2), product in [1,4)
    assign prod = fa * fb;

    //////////////////////////////////////////////////////////////////////
    // Control for both handshakes
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            req_ph   <= idle;
            res_ph   <= idle;
            busy     <= 1'b0;
            cap_v    <= 1'b0;
            s1_v     <= 1'b0;
            lane_ack <= 1'b0;
            res_req  <= 1'b0;
        end
        else
        begin
            // Pipeline valid chain
            cap_v <= (req_ph == req_seen);
            s1_v  <= cap_v;

            // Request side
            case (req_ph)
                idle:
                begin
                    if (lane_req && !busy)
                    begin
                        busy   <= 1'b1;
                        req_ph <= req_seen;
                    end
                end
                req_seen:
                begin
                    lane_ack <= 1'b1;
                    req_ph   <= ack_high;
                end
                ack_high:
                begin
                    if (!lane_req)
                    begin
                        lane_ack <= 1'b0;
                        req_ph   <= idle;
                    end
                end
                default: req_ph <= idle;
            endcase

            // Result side, frees the lane once res_ack is low again
            case (res_ph)
                idle:
                begin
                    if (s1_v)
                    begin
                        res_req <= 1'b1;
                        res_ph  <= req_seen;
                    end
                end
                req_seen:
                begin
                    if (res_ack)
                    begin
                        res_req <= 1'b0;
                        res_ph  <= wait_low;
                    end
                end
                wait_low:
                begin
                    if (!res_ack)
                    begin
                        busy   <= 1'b0;
                        res_ph <= idle;
                    end
                end
                default: res_ph <= idle;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        // Operands held by the dispatcher while lane_req is high
        if (req_ph == req_seen)
        begin
            a_q <= lane_a;
            b_q <= lane_b;
        end
        // Stage one
        if (cap_v)
        begin
            s1_sign  <= sa ^ sb;
            s1_nar   <= na | nb;
            // NaR beats zero
            s1_zero  <= (za | zb) & ~(na | nb);
            s1_scale <= sc_a + sc_b + SW'(prod[2*FW-1]);
            // Leading one to the top
            s1_prod  <= prod[2*FW-1] ? prod : prod << 1;
        end
        // Stage two
        if (s1_v)
            res_val <= rnd_p;
    end

    posit_rounding #(.N(N), .ES(ES)) u_round (
        .sign (s1_sign),
        .zero (s1_zero),
        .nar  (s1_nar),
        .scale(s1_scale),
        .frac ({s1_prod, 2'b00}),
        .p    (rnd_p)
    );

    // Ack answers a live request from the dispatcher
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(lane_ack) |-> lane_req);

    // Result held for the collector
    a_res_stable: assert property (@(posedge clk) disable iff (!rst_n)
        res_req && $past(res_req) |-> $stable(res_val));

endmodule

// ==== design/posit_dispatch.sv ====
`timescale 1ns/1ps

module posit_dispatch #(
    parameter int N     = posit_fmt_pkg::default_n,
    parameter int LANES = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_req,
    input  logic [N-1:0]     in_a,
    input  logic [N-1:0]     in_b,
    input  logic [LANES-1:0] lane_ack,
    output logic             in_ack,
    output logic [LANES-1:0] lane_req,
    output logic [N-1:0]     lane_a,
    output logic [N-1:0]     lane_b
);
    import posit_hs_pkg::*;

    localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

    hs_phase_e        phase;
    logic [PTR_W-1:0] ptr;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            phase    <= idle;
            ptr      <= '0;
            in_ack   <= 1'b0;
            lane_req <= '0;
        end
        else
        begin
            case (phase)
                // New job, request the lane at the pointer
                idle:
                begin
                    if (in_req)
                    begin
                        lane_req[ptr] <= 1'b1;
                        phase         <= req_seen;
                    end
                end
                req_seen:
                begin
                    if (lane_ack[ptr])
                    begin
                        lane_req[ptr] <= 1'b0;
                        phase         <= ack_high;
                    end
                end
                // Lane handshake done, then ack upstream
                ack_high:
                begin
                    if (!lane_ack[ptr])
                    begin
                        ptr    <= (ptr == PTR_W'(LANES - 1)) ? '0 : ptr + 1'b1;
                        in_ack <= 1'b1;
                        phase  <= wait_low;
                    end
                end
                wait_low:
                begin
                    if (!in_req)
                    begin
                        in_ack <= 1'b0;
                        phase  <= idle;
                    end
                end
                default: phase <= idle;
            endcase
        end
    end

    // Shared operand registers
    always_ff @(posedge clk)
    begin
        if (phase == idle && in_req)
        begin
            lane_a <= in_a;
            lane_b <= in_b;
        end
    end

    a_one_lane_req: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(lane_req));

endmodule

// ==== design/posit_collect.sv ====
`timescale 1ns/1ps

module posit_collect #(
    parameter int N     = posit_fmt_pkg::default_n,
    parameter int LANES = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [LANES-1:0]        res_req,
    input  logic [LANES-1:0][N-1:0] res_val,
    input  logic                    out_ack,
    output logic [LANES-1:0]        res_ack,
    output logic                    out_req,
    output logic [N-1:0]            out_val
);
    import posit_hs_pkg::*;

    localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

    hs_phase_e        phase;
    logic [PTR_W-1:0] ptr;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            phase   <= idle;
            ptr     <= '0;
            res_ack <= '0;
            out_req <= 1'b0;
        end
        else
        begin
            case (phase)
                // Only the lane at the pointer is served
                idle:
                begin
                    if (res_req[ptr])
                    begin
                        out_req <= 1'b1;
                        phase   <= req_seen;
                    end
                end
                // Downstream took it, release the lane
                req_seen:
                begin
                    if (out_ack)
                    begin
                        out_req      <= 1'b0;
                        res_ack[ptr] <= 1'b1;
                        phase        <= ack_high;
                    end
                end
                ack_high:
                begin
                    if (!res_req[ptr])
                    begin
                        res_ack[ptr] <= 1'b0;
                        phase        <= wait_low;
                    end
                end
                // Both sides low, next lane in job order
                wait_low:
                begin
                    if (!out_ack)
                    begin
                        ptr   <= (ptr == PTR_W'(LANES - 1)) ? '0 : ptr + 1'b1;
                        phase <= idle;
                    end
                end
                default: phase <= idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (phase == idle && res_req[ptr])
            out_val <= res_val[ptr];
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_req && $past(out_req) |-> $stable(out_val));

endmodule

// ==== design/posit_mul_array.sv ====
`timescale 1ns/1ps

module posit_mul_array #(
    parameter int N     = posit_fmt_pkg::default_n,
    parameter int ES    = posit_fmt_pkg::default_es,
    parameter int LANES = 4
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         in_req,
    input  logic [N-1:0] in_a,
    input  logic [N-1:0] in_b,
    output logic         in_ack,
    output logic         out_req,
    output logic [N-1:0] out_val,
    input  logic         out_ack
);

    // Dispatcher to lanes
    logic [LANES-1:0]        lane_req;
    logic [LANES-1:0]        lane_ack;
    logic [N-1:0]            lane_a;
    logic [N-1:0]            lane_b;
    // Lanes to collector
    logic [LANES-1:0]        res_req;
    logic [LANES-1:0]        res_ack;
    logic [LANES-1:0][N-1:0] res_val;

    posit_dispatch #(.N(N), .LANES(LANES)) u_dispatch (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_req  (in_req),
        .in_a    (in_a),
        .in_b    (in_b),
        .lane_ack(lane_ack),
        .in_ack  (in_ack),
        .lane_req(lane_req),
        .lane_a  (lane_a),
        .lane_b  (lane_b)
    );

    for (genvar i = 0; i < LANES; i++)
    begin : g_lane
        posit_mul_lane #(.N(N), .ES(ES)) u_lane (
            .clk     (clk),
            .rst_n   (rst_n),
            .lane_req(lane_req[i]),
            .lane_a  (lane_a),
            .lane_b  (lane_b),
            .res_ack (res_ack[i]),
            .lane_ack(lane_ack[i]),
            .res_req (res_req[i]),
            .res_val (res_val[i])
        );
    end

    posit_collect #(.N(N), .LANES(LANES)) u_collect (
        .clk    (clk),
        .rst_n  (rst_n),
        .res_req(res_req),
        .res_val(res_val),
        .out_ack(out_ack),
        .res_ack(res_ack),
        .out_req(out_req),
        .out_val(out_val)
    );

endmodule

// ==== verif/posit_ref_model.svh ====
`ifndef POSIT_REF_MODEL_SVH
`define POSIT_REF_MODEL_SVH

// Special patterns and saturation bounds
localparam logic [N-1:0] nar_pat     = {1'b1, {(N-1){1'b0}}};
localparam logic [N-1:0] maxpos_pat  = {1'b0, {(N-1){1'b1}}};
localparam logic [N-1:0] minpos_pat  = {{(N-1){1'b0}}, 1'b1};
localparam logic [N-1:0] one_pat     = {2'b01, {(N-2){1'b0}}};
localparam logic [N-1:0] neg_one_pat = {2'b11, {(N-2){1'b0}}};
// Longest possible fraction field
localparam int ref_fb = N - 3 - ES;

// Sign, scale and significand 1.f scaled by 2^ref_fb
function automatic void ref_decode(input logic [N-1:0] p, output logic s,
                                   output int sc, output longint sig);
    logic [N-1:0] mag;
    logic         r0;
    int           run;
    int           i;
    int           j;
    int           k;
    int           e;
    s   = p[N-1];
    mag = p[N-1] ? -p : p;
    r0  = mag[N-2];
    run = 0;
    i   = N - 2;
    while (i >= 0 && mag[i] == r0)
    begin
        run = run + 1;
        i   = i - 1;
    end
    k = r0 ? run - 1 : -run;
    // Skip the terminator
    i = i - 1;
    // Bits cut off by the regime read as zero
    e = 0;
    for (j = 0; j < ES; j++)
    begin
        e = e << 1;
        if (i >= 0)
            e = e | int'(mag[i]);
        i = i - 1;
    end
    sig = 1;
    for (j = 0; j < ref_fb; j++)
    begin
        sig = sig << 1;
        if (i >= 0)
            sig = sig | longint'(mag[i]);
        i = i - 1;
    end
    sc = (k << ES) + e;
endfunction

// Encode (-1)^s * 2^sc * 1.fr with fw fraction bits
// Bit string rounding, ties to even, clamped to minpos and maxpos
function automatic logic [N-1:0] ref_encode(input logic s, input int sc,
                                            input longint fr, input int fw);
    logic [127:0] str;
    logic [N-2:0] body;
    logic         guard;
    logic         sticky;
    logic [N-1:0] mag;
    int           k;
    int           e;
    int           pos;
    int           j;
    k   = sc >>> ES;
    e   = sc - (k << ES);
    str = '0;
    pos = 127;
    if (k >= 0)
    begin
        for (j = 0; j <= k; j++)
        begin
            str[pos] = 1'b1;
            pos      = pos - 1;
        end
        // Zero terminator left in place
        pos = pos - 1;
    end
    else
    begin
        pos      = pos + k;
        str[pos] = 1'b1;
        pos      = pos - 1;
    end
    for (j = ES - 1; j >= 0; j--)
    begin
        str[pos] = e[j];
        pos      = pos - 1;
    end
    for (j = fw - 1; j >= 0; j--)
    begin
        str[pos] = fr[j];
        pos      = pos - 1;
    end
    body   = str[127 -: N-1];
    guard  = str[127-(N-1)];
    sticky = |(str << N);
    mag    = {1'b0, body} + N'(guard & (sticky | body[0]));
    // Carry past maxpos or a result rounded away to nothing
    if (mag[N-1])
        mag = maxpos_pat;
    else if (mag == '0)
        mag = minpos_pat;
    if (s)
        mag = -mag;
    return mag;
endfunction

// Reference product of two posits
function automatic logic [N-1:0] ref_mul(input logic [N-1:0] a, input logic [N-1:0] b);
    logic   sa;
    logic   sb;
    int     sca;
    int     scb;
    int     sc;
    int     fw;
    longint ma;
    longint mb;
    longint prod;
    if (a == nar_pat || b == nar_pat)
        return nar_pat;
    if (a == '0 || b == '0)
        return '0;
    ref_decode(a, sa, sca, ma);
    ref_decode(b, sb, scb, mb);
    // Product in [1,4) with 2*ref_fb fraction bits
    prod = ma * mb;
    sc   = sca + scb;
    fw   = 2 * ref_fb;
    if (prod >= (longint'(1) << (fw + 1)))
    begin
        sc = sc + 1;
        fw = fw + 1;
    end
    // Drop the hidden one
    prod = prod - (longint'(1) << fw);
    return ref_encode(sa ^ sb, sc, prod, fw);
endfunction

`endif

// ==== verif/tb_posit_mul_array.sv ====
`timescale 1ns/1ps

module tb_posit_mul_array;

    localparam int N          = 16;
    localparam int ES         = 1;
    localparam int LANES      = 4;
    localparam int tmo_cycles = 400;
    localparam int n_jobs     = 20;

    `include "posit_ref_model.svh"

    logic         clk;
    logic         rst_n;
    logic         in_req;
    logic [N-1:0] in_a;
    logic [N-1:0] in_b;
    logic         in_ack;
    logic         out_req;
    logic [N-1:0] out_val;
    logic         out_ack;

    logic [31:0]  lfsr_q;
    int           error_count;
    int           timeout_count;

    // Job table for the back-pressure run
    logic [N-1:0] job_a [n_jobs];
    logic [N-1:0] job_b [n_jobs];
    logic [N-1:0] job_exp [n_jobs];
    int           job_stall [n_jobs];

    posit_mul_array #(.N(N), .ES(ES), .LANES(LANES)) u_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .in_req (in_req),
        .in_a   (in_a),
        .in_b   (in_b),
        .in_ack (in_ack),
        .out_req(out_req),
        .out_val(out_val),
        .out_ack(out_ack)
    );

    // 8 ns clock
    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int nbits);
        logic [31:0] val;
        logic        fb;
        int          i;
        val = '0;
        for (i = 0; i < nbits; i++)
        begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    task automatic note_timeout(input string msg);
        timeout_count = timeout_count + 1;
        $display("timeout at %0t ns: %s", $time, msg);
    endtask

    task automatic compare_posit(input logic [N-1:0] exp, input logic [N-1:0] act,
                                 input string what);
        if (act !== exp)
        begin
            error_count = error_count + 1;
            $display("error at %0t ns: %s expected %h got %h", $time, what, exp, act);
        end
    endtask

    task automatic compare_count(input int exp, input int act, input string what);
        if (act != exp)
        begin
            error_count = error_count + 1;
            $display("error at %0t ns: %s expected %0d got %0d", $time, what, exp, act);
        end
    endtask

    // Four-phase exchange on the input side
    task automatic send_job(input logic [N-1:0] a, input logic [N-1:0] b);
        int n;
        @(posedge clk);
        in_req <= 1'b1;
        in_a   <= a;
        in_b   <= b;
        n = 0;
        while (!in_ack && n < tmo_cycles)
        begin
            @(posedge clk);
            n = n + 1;
        end
        if (!in_ack)
            note_timeout("in_ack never rose after in_req");
        in_req <= 1'b0;
        n = 0;
        while (in_ack && n < tmo_cycles)
        begin
            @(posedge clk);
            n = n + 1;
        end
        if (in_ack)
            note_timeout("in_ack stayed high after in_req fell");
    endtask

    // Output side, optional stall before the ack
    task automatic recv_result(input int stall, output logic [N-1:0] val, output logic ok);
        int n;
        val = '0;
        ok  = 1'b0;
        n   = 0;
        while (!out_req && n < tmo_cycles)
        begin
            @(posedge clk);
            n = n + 1;
        end
        if (!out_req)
        begin
            note_timeout("out_req never rose");
        end
        else
        begin
            // Held stable while out_req is high
            val = out_val;
            ok  = 1'b1;
            repeat (stall) @(posedge clk);
            out_ack <= 1'b1;
            n = 0;
            while (out_req && n < tmo_cycles)
            begin
                @(posedge clk);
                n = n + 1;
            end
            if (out_req)
                note_timeout("out_req stayed high after out_ack rose");
            out_ack <= 1'b0;
        end
    endtask

    task automatic run_job(input logic [N-1:0] a, input logic [N-1:0] b,
                           input logic [N-1:0] exp);
        logic [N-1:0] got;
        logic         ok;
        send_job(a, b);
        recv_result(0, got, ok);
        if (ok)
            compare_posit(exp, got, $sformatf("%h * %h", a, b));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_identity_sign();
        logic [N-1:0] xs [8] = '{16'h4000, 16'h5000, 16'h3000, 16'h7fff,
                                 16'h0001, 16'h6a5c, 16'h1234, 16'hb7c3};
        int           i;
        for (i = 0; i < 8; i++)
        begin
            run_job(one_pat, xs[i], xs[i]);
            // Negation is the two's complement of the pattern
            run_job(xs[i], neg_one_pat, -xs[i]);
        end
    endtask

    task automatic test_specials();
        run_job('0, one_pat, '0);
        run_job(16'h5a31, '0, '0);
        run_job('0, maxpos_pat, '0);
        run_job(nar_pat, one_pat, nar_pat);
        run_job(one_pat, nar_pat, nar_pat);
        // NaR beats zero
        run_job(nar_pat, '0, nar_pat);
        run_job('0, nar_pat, nar_pat);
        run_job(nar_pat, nar_pat, nar_pat);
    endtask

    task automatic test_rounding();
        // Ties, odd neighbor up and even neighbor kept
        run_job(16'h4001, 16'h4800, 16'h4802);
        run_job(16'h4003, 16'h4800, 16'h4804);
        run_job(16'hbfff, 16'h4800, 16'hb7fe);
        // Just above and just below half an ulp
        run_job(16'h4001, 16'h4803, 16'h4805);
        run_job(16'h4001, 16'h47ff, 16'h4800);
    endtask

    task automatic test_saturation();
        run_job(maxpos_pat, maxpos_pat, maxpos_pat);
        run_job(minpos_pat, minpos_pat, minpos_pat);
        run_job(maxpos_pat, 16'h5000, maxpos_pat);
        run_job(minpos_pat, 16'h3000, minpos_pat);
        // Negative magnitudes
        run_job(-maxpos_pat, maxpos_pat, -maxpos_pat);
        run_job(-maxpos_pat, -maxpos_pat, maxpos_pat);
        run_job(-minpos_pat, minpos_pat, -minpos_pat);
        run_job(-minpos_pat, -minpos_pat, minpos_pat);
    endtask

    task automatic test_order_backpressure();
        logic [N-1:0] got;
        logic         ok;
        int           i;
        int           j;
        int           k;
        int           n_recv;
        // Operands and stalls drawn up front
        for (i = 0; i < n_jobs; i++)
        begin
            job_a[i]     = N'(take_bits(N));
            job_b[i]     = N'(take_bits(N));
            job_exp[i]   = ref_mul(job_a[i], job_b[i]);
            job_stall[i] = int'(take_bits(4));
        end
        n_recv = 0;
        fork
            begin
                for (j = 0; j < n_jobs; j++)
                    send_job(job_a[j], job_b[j]);
            end
            begin
                for (k = 0; k < n_jobs; k++)
                begin
                    recv_result(job_stall[k], got, ok);
                    if (ok)
                    begin
                        compare_posit(job_exp[k], got, $sformatf("job %0d", k));
                        n_recv = n_recv + 1;
                    end
                end
            end
        join
        compare_count(n_jobs, n_recv, "results received");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        in_req        = 1'b0;
        in_a          = '0;
        in_b          = '0;
        out_ack       = 1'b0;
        rst_n         = 1'b0;
        lfsr_q        = 32'h3a3f;
        error_count   = 0;
        timeout_count = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        test_identity_sign();
        test_specials();
        test_rounding();
        test_saturation();
        test_order_backpressure();

        $display("errors: %0d timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+verif
design/posit_fmt_pkg.sv
design/posit_hs_pkg.sv
design/posit_decode.sv
design/posit_rounding.sv
design/posit_mul_lane.sv
design/posit_dispatch.sv
design/posit_collect.sv
design/posit_mul_array.sv
verif/tb_posit_mul_array.sv

// ==== Makefile ====
TOP := tb_posit_mul_array
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and search the log for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
